//--- common/lsq_pkg.sv
package lsq_pkg;

  // Word address into the local data memory
  localparam int ADDR_W = 8;

  // Load and store data width
  localparam int DATA_W = 32;

  // Destination tag carried by a load back to the result port
  localparam int TAG_W = 6;

  // Load reading of the operation word
  // Pad fills the word out to the store width
  typedef struct packed {
    logic [ADDR_W-1:0]       addr;
    logic [TAG_W-1:0]        tag;
    logic [DATA_W-TAG_W-1:0] pad;
  } ld_view_t;

  // Store reading of the same word
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } st_view_t;

  // One operation word, read as a load or as a store
  typedef union packed {
    ld_view_t ld;
    st_view_t st;
  } op_word_u;

  // Request as it arrives on the four-phase port
  typedef struct packed {
    logic     is_store;
    op_word_u op;
  } mem_req_t;

  // Store waiting in the queue
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } stq_entry_t;

  // Load handed to the execution unit
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [TAG_W-1:0]  tag;
  } load_issue_t;

  // Completed load on the result port
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } load_result_t;

endpackage

//--- logic/mem_req_intake.sv
`timescale 1ns/1ps

module mem_req_intake (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  lsq_pkg::mem_req_t    req_pkt,
  input  logic                 stq_full,
  output logic                 ack,
  output logic                 stq_push,
  output lsq_pkg::stq_entry_t  stq_push_entry,
  output logic                 ld_issue,
  output lsq_pkg::load_issue_t ld_issue_pkt
);
  import lsq_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACKED,
    WAIT_FULL
  } state_t;

  state_t state;

  // Handshake control
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      ack      <= 1'b0;
      stq_push <= 1'b0;
      ld_issue <= 1'b0;
    end else begin
      // Push and issue are single-cycle pulses
      stq_push <= 1'b0;
      ld_issue <= 1'b0;
      case (state)
        IDLE: begin
          if (req) begin
            if (!req_pkt.is_store) begin
              ld_issue <= 1'b1;
              ack      <= 1'b1;
              state    <= ACKED;
            end else if (!stq_full) begin
              stq_push <= 1'b1;
              ack      <= 1'b1;
              state    <= ACKED;
            end else begin
              state <= WAIT_FULL;
            end
          end
        end
        WAIT_FULL: begin
          // Store already latched, hold ack until a slot frees up
          if (!stq_full) begin
            stq_push <= 1'b1;
            ack      <= 1'b1;
            state    <= ACKED;
          end
        end
        ACKED: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Payload capture, decoded through the view picked by is_store
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      if (req_pkt.is_store) begin
        stq_push_entry.addr <= req_pkt.op.st.addr;
        stq_push_entry.data <= req_pkt.op.st.data;
      end else begin
        ld_issue_pkt.addr <= req_pkt.op.ld.addr;
        ld_issue_pkt.tag  <= req_pkt.op.ld.tag;
      end
    end
  end

endmodule

//--- store_queue/store_queue.sv
`timescale 1ns/1ps

module store_queue #(
  parameter int STQ_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        push,
  input  lsq_pkg::stq_entry_t         push_entry,
  input  logic                        drain_ack,
  input  logic [lsq_pkg::ADDR_W-1:0]  fwd_addr,
  output logic                        full,
  output logic                        drain_valid,
  output lsq_pkg::stq_entry_t         drain_entry,
  output logic                        fwd_hit,
  output logic [lsq_pkg::DATA_W-1:0]  fwd_data
);
  import lsq_pkg::*;

  localparam int PTR_W = (STQ_DEPTH > 1) ? $clog2(STQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(STQ_DEPTH + 1);

  stq_entry_t       entries [STQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full        = (count == CNT_W'(STQ_DEPTH));
  assign drain_valid = (count != '0);
  assign drain_entry = entries[rd_ptr];

  assign do_push = push && !full;
  assign do_pop  = drain_ack && drain_valid;

  // Entry storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      entries[wr_ptr] <= push_entry;
    end
  end

  // Pointers wrap at STQ_DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(STQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(STQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy, push and pop may coincide
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Forwarding search
  // Walk from head (oldest) toward tail, later hits overwrite earlier ones
  // so the youngest matching store wins
  always_comb begin
    int unsigned slot;
    slot     = 0;
    fwd_hit  = 1'b0;
    fwd_data = '0;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      slot = int'(rd_ptr) + i;
      if (slot >= STQ_DEPTH) begin
        slot = slot - STQ_DEPTH;
      end
      if (i < int'(count) && entries[slot].addr == fwd_addr) begin
        fwd_hit  = 1'b1;
        fwd_data = entries[slot].data;
      end
    end
  end

endmodule

//--- logic/mem_exec_unit.sv
`timescale 1ns/1ps

module mem_exec_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        ld_issue,
  input  lsq_pkg::load_issue_t        ld_issue_pkt,
  input  logic                        fwd_hit,
  input  logic [lsq_pkg::DATA_W-1:0]  fwd_data,
  input  logic                        drain_valid,
  input  lsq_pkg::stq_entry_t         drain_entry,
  output logic [lsq_pkg::ADDR_W-1:0]  fwd_addr,
  output logic                        drain_ack,
  output logic                        res_valid,
  output lsq_pkg::load_result_t       res_pkt
);
  import lsq_pkg::*;

  localparam int MEM_WORDS = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [DATA_W-1:0] load_data;

  // Queue searches with the address of the load being issued
  assign fwd_addr = ld_issue_pkt.addr;

  // Single memory port, loads go first
  assign drain_ack = drain_valid && !ld_issue;

  // Forwarded store data beats the memory copy
  assign load_data = fwd_hit ? fwd_data : mem[ld_issue_pkt.addr];

  // Data memory with drain writes
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (drain_ack) begin
      mem[drain_entry.addr] <= drain_entry.data;
    end
  end

  // One-cycle load result pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= ld_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_issue) begin
      res_pkt.tag  <= ld_issue_pkt.tag;
      res_pkt.data <= load_data;
    end
  end

endmodule

//--- logic/lsq_top.sv
`timescale 1ns/1ps

module lsq_top #(
  parameter int STQ_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  lsq_pkg::mem_req_t     req_pkt,
  output logic                  ack,
  output logic                  res_valid,
  output lsq_pkg::load_result_t res_pkt
);
  import lsq_pkg::*;

  logic              stq_push;
  stq_entry_t        stq_push_entry;
  logic              stq_full;
  logic              ld_issue;
  load_issue_t       ld_issue_pkt;
  logic [ADDR_W-1:0] fwd_addr;
  logic              fwd_hit;
  logic [DATA_W-1:0] fwd_data;
  logic              drain_valid;
  stq_entry_t        drain_entry;
  logic              drain_ack;

  mem_req_intake i_intake (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .req_pkt        (req_pkt),
    .stq_full       (stq_full),
    .ack            (ack),
    .stq_push       (stq_push),
    .stq_push_entry (stq_push_entry),
    .ld_issue       (ld_issue),
    .ld_issue_pkt   (ld_issue_pkt)
  );

  store_queue #(
    .STQ_DEPTH (STQ_DEPTH)
  ) i_stq (
    .clk         (clk),
    .rst         (rst),
    .push        (stq_push),
    .push_entry  (stq_push_entry),
    .drain_ack   (drain_ack),
    .fwd_addr    (fwd_addr),
    .full        (stq_full),
    .drain_valid (drain_valid),
    .drain_entry (drain_entry),
    .fwd_hit     (fwd_hit),
    .fwd_data    (fwd_data)
  );

  mem_exec_unit i_exec (
    .clk          (clk),
    .rst          (rst),
    .ld_issue     (ld_issue),
    .ld_issue_pkt (ld_issue_pkt),
    .fwd_hit      (fwd_hit),
    .fwd_data     (fwd_data),
    .drain_valid  (drain_valid),
    .drain_entry  (drain_entry),
    .fwd_addr     (fwd_addr),
    .drain_ack    (drain_ack),
    .res_valid    (res_valid),
    .res_pkt      (res_pkt)
  );

endmodule

//--- verif/lsq_assert.sv
`timescale 1ns/1ps

module lsq_assert (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic stq_push,
  input logic stq_full,
  input logic drain_valid,
  input logic res_valid
);

  assert property (@(posedge clk) disable iff (rst) !(stq_push && stq_full))
    else $error("store pushed into a full queue");

  // A pushed store is waiting to drain on the next cycle
  assert property (@(posedge clk) disable iff (rst) stq_push |=> drain_valid)
    else $error("pushed store did not show up in the queue");

  // ack only rises in answer to a raised req
  assert property (@(posedge clk) disable iff (rst) (!req && !ack) |=> !ack)
    else $error("ack rose while req was low");

  assert property (@(posedge clk) rst |=> (!ack && !res_valid))
    else $error("ack or res_valid high out of reset");

endmodule

bind lsq_top lsq_assert i_assert (
  .clk         (clk),
  .rst         (rst),
  .req         (req),
  .ack         (ack),
  .stq_push    (stq_push),
  .stq_full    (stq_full),
  .drain_valid (drain_valid),
  .res_valid   (res_valid)
);

//--- verif/lsq_checker.sv
`timescale 1ns/1ps

module lsq_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  res_valid,
  input  lsq_pkg::load_result_t res_pkt,
  output int                    pass_cnt,
  output int                    fail_cnt,
  output int                    extra_cnt,
  output int                    loads_left
);
  import lsq_pkg::*;

  logic [8*24-1:0]   name_q [$];
  logic [TAG_W-1:0]  tag_q [$];
  logic [DATA_W-1:0] data_q [$];

  // Expected loads, in file order
  initial begin
    int              fd;
    int              n;
    string           line;
    logic [8*24-1:0] name;
    logic [7:0]      kind;
    logic [31:0]     addr;
    logic [31:0]     val;
    logic [31:0]     exp_val;
    pass_cnt  = 0;
    fail_cnt  = 0;
    extra_cnt = 0;
    fd = $fopen("verif/lsq_input.txt", "r");
    if (fd == 0) begin
      $display("checker could not open verif/lsq_input.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h", name, kind, addr, val, exp_val);
          if (n == 5 && kind == "L") begin
            name_q.push_back(name);
            tag_q.push_back(val[TAG_W-1:0]);
            data_q.push_back(exp_val);
          end
        end
      end
      $fclose(fd);
    end
    loads_left = name_q.size();
  end

  // Result pulse is steady around the falling edge
  always @(negedge clk) begin
    if (!rst && res_valid) begin
      if (name_q.size() == 0) begin
        $display("unexpected load result with tag %0h while no load was pending", res_pkt.tag);
        extra_cnt = extra_cnt + 1;
      end else begin
        if (res_pkt.tag == tag_q[0] && res_pkt.data == data_q[0]) begin
          $display("[PASS] %0s tag=%0h data=%h", name_q[0], res_pkt.tag, res_pkt.data);
          pass_cnt = pass_cnt + 1;
        end else begin
          $display("[FAIL] %0s expected tag=%0h data=%h actual tag=%0h data=%h",
                   name_q[0], tag_q[0], data_q[0], res_pkt.tag, res_pkt.data);
          fail_cnt = fail_cnt + 1;
        end
        void'(name_q.pop_front());
        void'(tag_q.pop_front());
        void'(data_q.pop_front());
        loads_left = name_q.size();
      end
    end
  end

endmodule

//--- verif/lsq_tb.sv
`timescale 1ns/1ps

module lsq_tb;
  import lsq_pkg::*;

  localparam int STQ_DEPTH  = 4;
  localparam int WAIT_LIMIT = 50;

  logic         clk;
  logic         rst;
  logic         req;
  mem_req_t     req_pkt;
  logic         ack;
  logic         res_valid;
  load_result_t res_pkt;
  int           pass_cnt;
  int           fail_cnt;
  int           extra_cnt;
  int           loads_left;
  int           fault_cnt;
  logic [31:0]  lcg_state;

  lsq_top #(
    .STQ_DEPTH (STQ_DEPTH)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_pkt   (req_pkt),
    .ack       (ack),
    .res_valid (res_valid),
    .res_pkt   (res_pkt)
  );

  lsq_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .res_valid  (res_valid),
    .res_pkt    (res_pkt),
    .pass_cnt   (pass_cnt),
    .fail_cnt   (fail_cnt),
    .extra_cnt  (extra_cnt),
    .loads_left (loads_left)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Four-phase transfer of one operation, entered and left on a falling edge
  task automatic send_op(input logic [8*24-1:0] name, input mem_req_t pkt);
    int waited;
    req_pkt = pkt;
    req     = 1'b1;
    waited  = 0;
    while (!ack && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!ack) begin
      $display("timeout: no ack for operation %0s", name);
      fault_cnt++;
    end
    req    = 1'b0;
    waited = 0;
    while (ack && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (ack) begin
      $display("timeout: ack stayed high after operation %0s", name);
      fault_cnt++;
    end
  endtask

  initial begin
    int              fd;
    int              n;
    int              waited;
    string           line;
    logic [8*24-1:0] name;
    logic [7:0]      kind;
    logic [31:0]     addr;
    logic [31:0]     val;
    logic [31:0]     exp_val;
    mem_req_t        pkt;
    clk       = 1'b0;
    rst       = 1'b1;
    req       = 1'b0;
    req_pkt   = '0;
    fault_cnt = 0;
    lcg_state = 32'he6c61349;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fd = $fopen("verif/lsq_input.txt", "r");
    if (fd == 0) begin
      $display("could not open stimulus file verif/lsq_input.txt");
      fault_cnt++;
    end else begin
      while (fault_cnt == 0 && $fgets(line, fd) > 0) begin
        if (line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h", name, kind, addr, val, exp_val);
          if (n == 5) begin
            pkt          = '0;
            pkt.is_store = (kind == "S");
            if (pkt.is_store) begin
              pkt.op.st.addr = addr[ADDR_W-1:0];
              pkt.op.st.data = val;
            end else begin
              pkt.op.ld.addr = addr[ADDR_W-1:0];
              pkt.op.ld.tag  = val[TAG_W-1:0];
            end
            send_op(name, pkt);
            // Idle gap of 0 to 3 cycles
            lcg_state = lcg_next(lcg_state);
            repeat (int'(lcg_state[31:30])) @(negedge clk);
          end
        end
      end
      $fclose(fd);
    end

    waited = 0;
    while (loads_left > 0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (loads_left > 0) begin
      $display("timeout: %0d expected load results never arrived", loads_left);
      fault_cnt++;
    end
    // Catch stray results
    repeat (4) @(negedge clk);

    $display("passed %0d, failed %0d, unexpected %0d, other errors %0d",
             pass_cnt, fail_cnt, extra_cnt, fault_cnt);
    if (pass_cnt > 0 && fail_cnt == 0 && extra_cnt == 0 && fault_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verif/lsq_input.txt
# name  kind(S store, L load)  addr(hex)  store data or load tag(hex)  expected load data(hex)
# The expected column is 0 on store lines and is not used there
cold_load    L 10 01 00000000
fwd_store    S 20 cafe0001 0
fwd_load     L 20 02 cafe0001
multi_st_a   S 30 11111111 0
multi_st_b   S 30 22222222 0
multi_st_c   S 30 33333333 0
multi_load   L 30 03 33333333
burst_st_0   S 40 a0000000 0
burst_st_1   S 41 a0000001 0
burst_st_2   S 42 a0000002 0
burst_st_3   S 43 a0000003 0
burst_st_4   S 44 a0000004 0
burst_st_5   S 45 a0000005 0
burst_ld_0   L 40 04 a0000000
burst_ld_1   L 41 05 a0000001
burst_ld_2   L 42 06 a0000002
burst_ld_3   L 43 07 a0000003
burst_ld_4   L 44 08 a0000004
burst_ld_5   L 45 09 a0000005
mix_st_a     S 50 55550000 0
mix_ld_other L 20 0a cafe0001
mix_st_b     S 51 55551111 0
mix_ld_a     L 50 0b 55550000
mix_ld_b     L 51 0c 55551111
cold_after   L 60 0d 00000000

//--- build.f
common/lsq_pkg.sv
logic/mem_req_intake.sv
store_queue/store_queue.sv
logic/mem_exec_unit.sv
logic/lsq_top.sv
verif/lsq_assert.sv
verif/lsq_checker.sv
verif/lsq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the load/store queue testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module lsq_tb \
    -o lsq_sim > build.log 2>&1 \
  && ./obj_dir/lsq_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation did not complete"; }

cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
